//--- common/psrPkg.sv
`default_nettype none

package psrPkg;

  // Status word layout {N,Z,C,V, I, F, T, mode[4:0]}
  localparam int psrWidth = 12;
  localparam int flagsLsb = 8;   // NZCV at [11:8]
  localparam int iBit = 7;
  localparam int fBit = 6;
  localparam int tBit = 5;
  localparam int modeMsb = 4;    // Mode field is [4:0]

  localparam int bankCount = 5;  // svc abt und irq fiq

  // Processor modes
  localparam logic [modeMsb:0] modeUsr = 5'b10000;
  localparam logic [modeMsb:0] modeFiq = 5'b10001;
  localparam logic [modeMsb:0] modeIrq = 5'b10010;
  localparam logic [modeMsb:0] modeSvc = 5'b10011;
  localparam logic [modeMsb:0] modeAbt = 5'b10111;
  localparam logic [modeMsb:0] modeUnd = 5'b11011;
  localparam logic [modeMsb:0] modeSys = 5'b11111;

  // Offsets into the exception table
  localparam logic [psrWidth-1:0] vecUndef = 12'h004;
  localparam logic [psrWidth-1:0] vecSwi = 12'h008;
  localparam logic [psrWidth-1:0] vecPrefetch = 12'h00C;
  localparam logic [psrWidth-1:0] vecData = 12'h010;
  localparam logic [psrWidth-1:0] vecIrq = 12'h018;
  localparam logic [psrWidth-1:0] vecFiq = 12'h01C;

  // Flags clear, both interrupts masked, ARM state, supervisor
  localparam logic [psrWidth-1:0] resetPsr = {4'b0000, 1'b1, 1'b1, 1'b0, modeSvc};

  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl, condNv
  } condCode;

  // Slot of a mode in the banked registers
  // banked is low for usr, sys and unknown codes
  function automatic logic [2:0] bankIndex(input logic [modeMsb:0] mode,
                                           output logic banked);
    logic [2:0] slot;
    slot = 3'd0;
    banked = 1'b1;
    case (mode)
      modeSvc: slot = 3'd0;
      modeAbt: slot = 3'd1;
      modeUnd: slot = 3'd2;
      modeIrq: slot = 3'd3;
      modeFiq: slot = 3'd4;
      default: banked = 1'b0;  // usr, sys, garbage
    endcase
    return slot;
  endfunction

endpackage

`default_nettype wire

//--- hw/exceptionPriority.sv
`timescale 1ns/1ns
`default_nettype none

module exceptionPriority #(
  parameter int addrWidth = 32,
  parameter logic [addrWidth-1:0] vectorBase = '0
) (
  input  logic [psrPkg::psrWidth-1:0] cpsr,
  input  logic                        undefinedInstr,
  input  logic                        softwareInterrupt,
  input  logic                        prefetchAbort,
  input  logic                        dataAbort,
  input  logic                        irq,
  input  logic                        fiq,
  output logic                        take,
  output logic [psrPkg::modeMsb:0]    takeMode,
  output logic                        setFiqMask,
  output logic [addrWidth-1:0]        vectorAddr
);

  logic [psrPkg::modeMsb:0] curMode;
  logic dataOk;
  logic fiqOk;
  logic irqOk;
  logic prefetchOk;
  logic undefOk;
  logic swiOk;
  logic [psrPkg::psrWidth-1:0] offset;  // Table offset of the winner

  assign curMode = cpsr[psrPkg::modeMsb:0];

  // A line whose target mode is already current is ignored
  assign dataOk = dataAbort & (curMode != psrPkg::modeAbt);
  assign fiqOk = fiq & ~cpsr[psrPkg::fBit] & (curMode != psrPkg::modeFiq);  // F masks
  assign irqOk = irq & ~cpsr[psrPkg::iBit] & (curMode != psrPkg::modeIrq);  // I masks
  assign prefetchOk = prefetchAbort & (curMode != psrPkg::modeAbt);
  assign undefOk = undefinedInstr & (curMode != psrPkg::modeUnd);
  assign swiOk = softwareInterrupt & (curMode != psrPkg::modeSvc);

  // Fixed priority from data abort down to SWI
  always_comb begin
    take = 1'b1;
    takeMode = curMode;
    setFiqMask = 1'b0;
    offset = '0;
    if (dataOk) begin
      takeMode = psrPkg::modeAbt;
      offset = psrPkg::vecData;
    end else if (fiqOk) begin
      takeMode = psrPkg::modeFiq;
      setFiqMask = 1'b1;  // Only FIQ masks further FIQs
      offset = psrPkg::vecFiq;
    end else if (irqOk) begin
      takeMode = psrPkg::modeIrq;
      offset = psrPkg::vecIrq;
    end else if (prefetchOk) begin
      takeMode = psrPkg::modeAbt;  // Shares abort mode with data abort
      offset = psrPkg::vecPrefetch;
    end else if (undefOk) begin
      takeMode = psrPkg::modeUnd;
      offset = psrPkg::vecUndef;
    end else if (swiOk) begin
      takeMode = psrPkg::modeSvc;
      offset = psrPkg::vecSwi;
    end else begin
      take = 1'b0;  // Nothing pending
    end
  end

  // Zero when idle so the fetch side sees no stray target
  assign vectorAddr = take ? vectorBase + addrWidth'(offset) : '0;

endmodule

`default_nettype wire

//--- psr/statusRegister.sv
`timescale 1ns/1ns
`default_nettype none

module statusRegister (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          take,
  input  logic [psrPkg::modeMsb:0]                      takeMode,
  input  logic                                          setFiqMask,
  input  logic                                          exceptionReturn,
  input  logic [psrPkg::psrWidth-1:0]                   spsr,
  input  logic                                          flagsWrite,
  input  logic [psrPkg::psrWidth-psrPkg::flagsLsb-1:0]  flagsNext,
  output logic [psrPkg::psrWidth-1:0]                   cpsr
);

  logic [psrPkg::modeMsb:0] curMode;
  logic returnOk;                          // Current mode has its own SPSR
  logic [psrPkg::psrWidth-1:0] entryPsr;   // Status word on exception entry
  logic [psrPkg::psrWidth-1:0] flagsPsr;   // Status word after a flag update
  logic [psrPkg::psrWidth-1:0] nextCpsr;

  assign curMode = cpsr[psrPkg::modeMsb:0];

  // Only the banked flag matters here
  always_comb begin
    void'(psrPkg::bankIndex(curMode, returnOk));
  end

  // Entry keeps NZCV, forces ARM state and masks IRQ
  always_comb begin
    entryPsr = cpsr;
    entryPsr[psrPkg::modeMsb:0] = takeMode;
    entryPsr[psrPkg::tBit] = 1'b0;  // Back to ARM state
    entryPsr[psrPkg::iBit] = 1'b1;
    entryPsr[psrPkg::fBit] = cpsr[psrPkg::fBit] | setFiqMask;  // F kept unless FIQ
  end

  // Flag writes touch NZCV only
  always_comb begin
    flagsPsr = cpsr;
    flagsPsr[psrPkg::psrWidth-1:psrPkg::flagsLsb] = flagsNext;
  end

  // Entry beats return beats flag write
  always_comb begin
    if (take) begin
      nextCpsr = entryPsr;
    end else if (exceptionReturn && returnOk) begin
      nextCpsr = spsr;  // Restore the interrupted context
    end else if (flagsWrite) begin
      nextCpsr = flagsPsr;
    end else begin
      nextCpsr = cpsr;  // Hold
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cpsr <= psrPkg::resetPsr;  // Supervisor with I and F set
    end else begin
      cpsr <= nextCpsr;
    end
  end

endmodule

`default_nettype wire

//--- psr/spsrBank.sv
`timescale 1ns/1ns
`default_nettype none

module spsrBank (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        take,
  input  logic [psrPkg::modeMsb:0]    takeMode,
  input  logic [psrPkg::psrWidth-1:0] cpsr,
  output logic [psrPkg::psrWidth-1:0] spsr
);

  logic [psrPkg::psrWidth-1:0] spsrReg [psrPkg::bankCount];
  logic [2:0] takeSlot;
  logic takeBanked;
  logic [2:0] curSlot;
  logic curBanked;

  always_comb begin
    takeSlot = psrPkg::bankIndex(takeMode, takeBanked);  // Write side
    curSlot = psrPkg::bankIndex(cpsr[psrPkg::modeMsb:0], curBanked);  // Read side
  end

  // Save the pre-entry status in the target mode's slot
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < psrPkg::bankCount; i++) begin
        spsrReg[i] <= '0;
      end
    end else if (take && takeBanked) begin
      spsrReg[takeSlot] <= cpsr;  // Old cpsr, before the mode switch
    end
  end

  // usr and sys have no SPSR, so they see cpsr itself
  always_comb begin
    if (curBanked) begin
      spsr = spsrReg[curSlot];
    end else begin
      spsr = cpsr;
    end
  end

endmodule

`default_nettype wire

//--- hw/linkBank.sv
`timescale 1ns/1ns
`default_nettype none

module linkBank #(
  parameter int addrWidth = 32
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        take,
  input  logic [psrPkg::modeMsb:0]    takeMode,
  input  logic [addrWidth-1:0]        returnAddress,
  input  logic [psrPkg::psrWidth-1:0] cpsr,
  output logic [addrWidth-1:0]        returnPc
);

  // One r14 per exception mode
  logic [addrWidth-1:0] lrReg [psrPkg::bankCount];
  logic [2:0] takeSlot;
  logic takeBanked;
  logic [2:0] curSlot;
  logic curBanked;

  always_comb begin
    takeSlot = psrPkg::bankIndex(takeMode, takeBanked);
    curSlot = psrPkg::bankIndex(cpsr[psrPkg::modeMsb:0], curBanked);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < psrPkg::bankCount; i++) begin
        lrReg[i] <= '0;
      end
    end else if (take && takeBanked) begin
      lrReg[takeSlot] <= returnAddress;  // Captured in the entry cycle
    end
  end

  // Unbanked modes have no link to return through
  always_comb begin
    if (curBanked) begin
      returnPc = lrReg[curSlot];
    end else begin
      returnPc = '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/conditionCheck.sv
`timescale 1ns/1ns
`default_nettype none

module conditionCheck (
  input  logic [3:0]                  cond,
  input  logic [psrPkg::psrWidth-1:0] cpsr,
  output logic                        condPass
);

  psrPkg::condCode condSel;
  logic n;
  logic z;
  logic c;
  logic v;

  assign condSel = psrPkg::condCode'(cond);
  assign {n, z, c, v} = cpsr[psrPkg::psrWidth-1:psrPkg::flagsLsb];

  always_comb begin
    case (condSel)
      psrPkg::condEq: condPass = z;
      psrPkg::condNe: condPass = ~z;
      psrPkg::condCs: condPass = c;           // Unsigned higher or same
      psrPkg::condCc: condPass = ~c;          // Unsigned lower
      psrPkg::condMi: condPass = n;
      psrPkg::condPl: condPass = ~n;
      psrPkg::condVs: condPass = v;
      psrPkg::condVc: condPass = ~v;
      psrPkg::condHi: condPass = c & ~z;      // Unsigned higher
      psrPkg::condLs: condPass = ~c | z;
      psrPkg::condGe: condPass = (n == v);    // Signed compares
      psrPkg::condLt: condPass = (n != v);
      psrPkg::condGt: condPass = ~z & (n == v);
      psrPkg::condLe: condPass = z | (n != v);
      // AL and NV both execute
      default: condPass = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/exceptionControl.sv
`timescale 1ns/1ns
`default_nettype none

module exceptionControl #(
  parameter int addrWidth = 32,
  parameter logic [addrWidth-1:0] vectorBase = '0  // 32'hFFFF0000 for high vectors
) (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          undefinedInstr,
  input  logic                                          softwareInterrupt,
  input  logic                                          prefetchAbort,
  input  logic                                          dataAbort,
  input  logic                                          irq,
  input  logic                                          fiq,
  input  logic                                          flagsWrite,
  input  logic [psrPkg::psrWidth-psrPkg::flagsLsb-1:0]  flagsNext,
  input  logic                                          exceptionReturn,
  input  logic [addrWidth-1:0]                          returnAddress,
  input  logic [3:0]                                    cond,
  output logic [psrPkg::psrWidth-1:0]                   cpsr,
  output logic [psrPkg::psrWidth-1:0]                   spsr,
  output logic                                          exceptionTaken,
  output logic [addrWidth-1:0]                          vectorAddr,
  output logic [addrWidth-1:0]                          returnPc,
  output logic                                          condPass
);

  logic take;                          // Entry this cycle
  logic [psrPkg::modeMsb:0] takeMode;
  logic setFiqMask;

  exceptionPriority #(
    .addrWidth(addrWidth),
    .vectorBase(vectorBase)
  ) exceptionPriority_i (
    .cpsr(cpsr),
    .undefinedInstr(undefinedInstr),
    .softwareInterrupt(softwareInterrupt),
    .prefetchAbort(prefetchAbort),
    .dataAbort(dataAbort),
    .irq(irq),
    .fiq(fiq),
    .take(take),
    .takeMode(takeMode),
    .setFiqMask(setFiqMask),
    .vectorAddr(vectorAddr)
  );

  statusRegister statusRegister_i (
    .clk(clk),
    .reset(reset),
    .take(take),
    .takeMode(takeMode),
    .setFiqMask(setFiqMask),
    .exceptionReturn(exceptionReturn),
    .spsr(spsr),
    .flagsWrite(flagsWrite),
    .flagsNext(flagsNext),
    .cpsr(cpsr)
  );

  spsrBank spsrBank_i (
    .clk(clk),
    .reset(reset),
    .take(take),
    .takeMode(takeMode),
    .cpsr(cpsr),
    .spsr(spsr)
  );

  linkBank #(
    .addrWidth(addrWidth)
  ) linkBank_i (
    .clk(clk),
    .reset(reset),
    .take(take),
    .takeMode(takeMode),
    .returnAddress(returnAddress),
    .cpsr(cpsr),
    .returnPc(returnPc)
  );

  conditionCheck conditionCheck_i (
    .cond(cond),
    .cpsr(cpsr),
    .condPass(condPass)
  );

  assign exceptionTaken = take;

endmodule

`default_nettype wire

//--- test/exceptionControlTb.sv
`timescale 1ns/1ns
`default_nettype none

module exceptionControlTb;

  localparam int resetCycles = 10;
  localparam int flagCycles = 64 + 32;    // Random writes, then two per condition
  localparam int priorityCycles = 200;
  localparam int entryCycles = 80;        // Entry and return pairs
  localparam int returnCycles = 80;
  localparam int mixCycles = 500;
  localparam int cycleLimit = 2 * (resetCycles + 2 + flagCycles + priorityCycles
                                   + entryCycles + returnCycles + mixCycles);
  // Flags clear, I and F set, ARM state, supervisor
  localparam logic [11:0] resetWord = {4'b0000, 1'b1, 1'b1, 1'b0, psrPkg::modeSvc};
  localparam logic [2:0] noSlot = 3'd7;

  logic clk;
  logic reset;
  logic undefinedInstr;
  logic softwareInterrupt;
  logic prefetchAbort;
  logic dataAbort;
  logic irq;
  logic fiq;
  logic flagsWrite;
  logic [3:0] flagsNext;
  logic exceptionReturn;
  logic [31:0] returnAddress;
  logic [3:0] cond;
  logic [11:0] cpsr;
  logic [11:0] spsr;
  logic exceptionTaken;
  logic [31:0] vectorAddr;
  logic [31:0] returnPc;
  logic condPass;

  // Reference state
  logic [11:0] mCpsr;
  logic [11:0] mSpsr [0:4];
  logic [31:0] mLr [0:4];
  logic [31:0] lfsrState;
  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  int takenCount = 0;

  exceptionControl exceptionControl_i (
    .clk(clk), .reset(reset),
    .undefinedInstr(undefinedInstr), .softwareInterrupt(softwareInterrupt),
    .prefetchAbort(prefetchAbort), .dataAbort(dataAbort), .irq(irq), .fiq(fiq),
    .flagsWrite(flagsWrite), .flagsNext(flagsNext), .exceptionReturn(exceptionReturn),
    .returnAddress(returnAddress), .cond(cond),
    .cpsr(cpsr), .spsr(spsr), .exceptionTaken(exceptionTaken),
    .vectorAddr(vectorAddr), .returnPc(returnPc), .condPass(condPass)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Guard against a stuck run
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: run went past %0d cycles", cycleLimit);
      $display("Testbench failed");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);  // One step per bit
      val = {val[30:0], lfsrState[0]};
    end
    return val;
  endfunction

  // Bank slot of a mode, noSlot when it has none
  function automatic logic [2:0] modeSlot(input logic [4:0] md);
    case (md)
      psrPkg::modeSvc: return 3'd0;
      psrPkg::modeAbt: return 3'd1;
      psrPkg::modeUnd: return 3'd2;
      psrPkg::modeIrq: return 3'd3;
      psrPkg::modeFiq: return 3'd4;
      default: return noSlot;
    endcase
  endfunction

  function automatic logic condExpected(input logic [3:0] cd, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cd)
      4'h0: return z;
      4'h1: return ~z;
      4'h2: return c;
      4'h3: return ~c;
      4'h4: return n;
      4'h5: return ~n;
      4'h6: return v;
      4'h7: return ~v;
      4'h8: return c & ~z;
      4'h9: return ~c | z;
      4'hA: return n == v;
      4'hB: return n != v;
      4'hC: return ~z & (n == v);
      4'hD: return z | (n != v);
      default: return 1'b1;  // AL, NV
    endcase
  endfunction

  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Winner among the lines for the model's current state
  task automatic predictException(output logic tk, output logic [4:0] md, output logic fm,
                                  output logic [31:0] vec);
    logic [4:0] cur;
    cur = mCpsr[4:0];
    tk = 1'b1;
    md = cur;
    fm = 1'b0;
    vec = '0;
    if (dataAbort && cur != psrPkg::modeAbt) begin
      md = psrPkg::modeAbt;
      vec = 32'h10;
    end else if (fiq && !mCpsr[6] && cur != psrPkg::modeFiq) begin
      md = psrPkg::modeFiq;
      fm = 1'b1;
      vec = 32'h1C;
    end else if (irq && !mCpsr[7] && cur != psrPkg::modeIrq) begin
      md = psrPkg::modeIrq;
      vec = 32'h18;
    end else if (prefetchAbort && cur != psrPkg::modeAbt) begin
      md = psrPkg::modeAbt;
      vec = 32'h0C;
    end else if (undefinedInstr && cur != psrPkg::modeUnd) begin
      md = psrPkg::modeUnd;
      vec = 32'h04;
    end else if (softwareInterrupt && cur != psrPkg::modeSvc) begin
      md = psrPkg::modeSvc;
      vec = 32'h08;
    end else begin
      tk = 1'b0;
    end
  endtask

  task automatic driveIdle;
    {dataAbort, fiq, irq, prefetchAbort, undefinedInstr, softwareInterrupt} = '0;
    flagsWrite = 1'b0;
    flagsNext = 4'h0;
    exceptionReturn = 1'b0;
    returnAddress = '0;
    cond = 4'h0;
  endtask

  task automatic randomLines;
    logic [5:0] l;
    for (int i = 0; i < 6; i++) begin
      l[i] = (randBits(2) == 32'd3);  // Each line high one time in four
    end
    {dataAbort, fiq, irq, prefetchAbort, undefinedInstr, softwareInterrupt} = l;
  endtask

  // Entered at edge + 1 with inputs set, leaves at the next edge + 1
  task automatic runCycle;
    logic tk;
    logic [4:0] md;
    logic fm;
    logic [31:0] vec;
    logic [2:0] curSlot;
    logic [2:0] wrSlot;
    logic [11:0] nextCpsr;
    logic [31:0] wrAddr;
    #2;
    predictException(tk, md, fm, vec);
    curSlot = modeSlot(mCpsr[4:0]);
    checkValue(32'(exceptionTaken), 32'(tk), "exceptionTaken");
    checkValue(vectorAddr, vec, "vectorAddr");
    checkValue(32'(cpsr), 32'(mCpsr), "cpsr");
    checkValue(32'(spsr), 32'(curSlot != noSlot ? mSpsr[curSlot] : mCpsr), "spsr");
    checkValue(returnPc, curSlot != noSlot ? mLr[curSlot] : 32'h0, "returnPc");
    checkValue(32'(condPass), 32'(condExpected(cond, mCpsr[11:8])), "condPass");
    nextCpsr = mCpsr;
    wrSlot = noSlot;
    wrAddr = returnAddress;
    if (tk) begin
      takenCount++;
      nextCpsr = {mCpsr[11:8], 1'b1, mCpsr[6] | fm, 1'b0, md};  // I set, T clear
      wrSlot = modeSlot(md);
    end else if (exceptionReturn && curSlot != noSlot) begin
      nextCpsr = mSpsr[curSlot];
    end else if (flagsWrite) begin
      nextCpsr = {flagsNext, mCpsr[7:0]};
    end
    @(posedge clk);
    #1;
    if (wrSlot != noSlot) begin
      mSpsr[wrSlot] = mCpsr;  // Pre-entry word
      mLr[wrSlot] = wrAddr;
    end
    mCpsr = nextCpsr;
  endtask

  task automatic finishTest(input string name, input int errStart);
    $display("Test %s finished with %0d errors", name, errorCount - errStart);
  endtask

  initial begin
    int errStart;
    int idx;
    logic tk;
    logic [4:0] md;
    logic fm;
    logic [31:0] vec;
    logic [11:0] preCpsr;
    logic [11:0] expCpsr;
    logic [31:0] addr;
    logic [2:0] slot;
    lfsrState = 32'hf22a_92f1;
    reset = 1'b1;
    driveIdle();
    mCpsr = resetWord;
    for (int i = 0; i < 5; i++) begin
      mSpsr[i] = '0;
      mLr[i] = '0;
    end
    repeat (resetCycles) @(posedge clk);
    #1;
    reset = 1'b0;

    errStart = errorCount;
    checkValue(32'(cpsr), 32'(resetWord), "cpsr after reset");
    checkValue(32'(exceptionTaken), 32'h0, "exceptionTaken after reset");
    checkValue(32'(spsr), 32'h0, "spsr after reset");
    checkValue(returnPc, 32'h0, "returnPc after reset");
    repeat (2) runCycle();
    finishTest("reset", errStart);

    errStart = errorCount;
    repeat (64) begin
      flagsWrite = 1'(randBits(1));
      flagsNext = 4'(randBits(4));
      cond = 4'(randBits(4));
      runCycle();
    end
    for (int c = 0; c < 16; c++) begin
      cond = 4'(c);
      flagsWrite = 1'b1;
      flagsNext = 4'(randBits(4));
      runCycle();
      flagsWrite = 1'b0;  // Same condition on the new flags
      runCycle();
    end
    finishTest("flags and conditions", errStart);

    // Return from svc with an empty SPSR leaves both masks clear
    errStart = errorCount;
    driveIdle();
    exceptionReturn = 1'b1;
    runCycle();
    repeat (priorityCycles - 1) begin
      driveIdle();
      randomLines();
      exceptionReturn = (randBits(3) == 32'd7);
      returnAddress = randBits(32);
      runCycle();
    end
    finishTest("priority and masking", errStart);

    errStart = errorCount;
    repeat (entryCycles / 2) begin
      driveIdle();
      idx = int'(randBits(3)) % 6;
      {dataAbort, fiq, irq, prefetchAbort, undefinedInstr, softwareInterrupt} =
        6'b000001 << idx;
      returnAddress = randBits(32);
      predictException(tk, md, fm, vec);
      preCpsr = mCpsr;
      addr = returnAddress;
      runCycle();
      if (tk) begin
        checkValue(32'(spsr), 32'(preCpsr), "spsr after entry");
        checkValue(returnPc, addr, "returnPc after entry");
      end
      driveIdle();
      exceptionReturn = 1'(randBits(1));
      runCycle();
    end
    finishTest("entry saving", errStart);

    errStart = errorCount;
    repeat (returnCycles / 2) begin
      driveIdle();
      randomLines();
      returnAddress = randBits(32);
      runCycle();
      driveIdle();
      exceptionReturn = 1'b1;
      slot = modeSlot(mCpsr[4:0]);
      expCpsr = (slot != noSlot) ? mSpsr[slot] : mCpsr;
      runCycle();
      checkValue(32'(cpsr), 32'(expCpsr), "cpsr after return");
    end
    finishTest("exception return", errStart);

    errStart = errorCount;
    repeat (mixCycles) begin
      randomLines();
      flagsWrite = 1'(randBits(1));
      flagsNext = 4'(randBits(4));
      exceptionReturn = (randBits(3) == 32'd7);
      returnAddress = randBits(32);
      cond = 4'(randBits(4));
      runCycle();
    end
    finishTest("random mix", errStart);

    $display("%0d checks, %0d errors, %0d exceptions taken",
             checkCount, errorCount, takenCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
common/psrPkg.sv
hw/exceptionPriority.sv
psr/statusRegister.sv
psr/spsrBank.sv
hw/linkBank.sv
hw/conditionCheck.sv
hw/exceptionControl.sv
test/exceptionControlTb.sv

//--- run.sh
#!/bin/sh
# Build and run the exceptionControl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
  -f list.f --top-module exceptionControlTb -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
